//--- hdl/kv_defines_pkg.sv
// vault geometry is fixed here; a client DATA_WIDTH/32 must not exceed KV_NUM_DWORDS
package kv_defines_pkg;

    // number of vault entries and index width
    localparam int KV_NUM_ENTRIES = 8;
    localparam int KV_ENTRY_W     = 3;

    // dwords per entry and dword offset width
    localparam int KV_NUM_DWORDS  = 8;
    localparam int KV_DWORD_OFF_W = 3;

    // destination-valid mask, one bit per consumer
    localparam int KV_DEST_W      = 4;

    // per-client control register
    // bit 0 is the enable, cleared by hardware when the transfer completes
    typedef struct packed {
        logic [23:0]           rsvd;
        logic [KV_DEST_W-1:0]  write_dest_vld;
        logic [KV_ENTRY_W-1:0] write_entry;
        logic                  write_en;
    } kv_write_ctrl_reg_t;

    // store lock command
    // lock_wr qualifies the command, set picks lock or unlock
    typedef struct packed {
        logic [26:0]           rsvd;
        logic                  set;
        logic                  lock_wr;
        logic [KV_ENTRY_W-1:0] entry;
    } kv_lock_cmd_t;

    // host data word, meaning chosen by host address
    typedef union packed {
        kv_write_ctrl_reg_t ctrl;
        kv_lock_cmd_t       lock;
    } kv_host_word_u;

    // one write beat from a client
    // dest mask is nonzero only on the final beat
    typedef struct packed {
        logic                      write_en;
        logic [KV_ENTRY_W-1:0]     write_entry;
        logic [KV_DWORD_OFF_W-1:0] write_offset;
        logic [31:0]               write_data;
        logic [KV_DEST_W-1:0]      write_dest_valid;
    } kv_write_t;

    // same-cycle response to a beat
    typedef struct packed {
        logic error;
    } kv_wr_resp_t;

    // client status after a transfer
    typedef enum logic [7:0] {
        KV_SUCCESS    = 8'h00,
        KV_WRITE_FAIL = 8'h01
    } kv_error_code_e;

endpackage

//--- hdl/kv_fsm.sv
// no padding or extend modes; a zero or oversize num_dwords runs the full DATA_WIDTH/32 beats
module kv_fsm #(
    parameter int DATA_WIDTH = 256
) (
    input  logic                                       clk,
    input  logic                                       rst_b,
    input  logic                                       zeroize,
    input  logic                                       start,
    input  logic [kv_defines_pkg::KV_DWORD_OFF_W:0]    num_dwords,
    output logic [kv_defines_pkg::KV_DWORD_OFF_W-1:0]  read_offset,
    output logic [kv_defines_pkg::KV_DWORD_OFF_W-1:0]  write_offset,
    output logic                                       write_en,
    output logic                                       write_last,
    output logic                                       ready,
    output logic                                       done
);
    localparam int OFF_W = kv_defines_pkg::KV_DWORD_OFF_W;
    localparam logic [OFF_W:0] MAX_NUM = (OFF_W + 1)'(DATA_WIDTH / 32);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e           state;
    logic [OFF_W-1:0] cnt;
    logic [OFF_W-1:0] last_q;
    logic [OFF_W:0]   eff_num;

    // clamp the requested length to the word size
    always_comb begin
        if (num_dwords == '0 || num_dwords > MAX_NUM) begin
            eff_num = MAX_NUM;
        end else begin
            eff_num = num_dwords;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            last_q <= '0;
        end else if (zeroize) begin
            // drop any running sequence
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            unique case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state  <= ST_WRITE;
                        cnt    <= '0;
                        // length is latched so a host change mid-run has no effect
                        last_q <= OFF_W'(eff_num - 1'b1);
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (cnt == last_q) begin
                        state <= ST_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one beat per cycle while writing
    assign write_en     = (state == ST_WRITE);
    assign read_offset  = cnt;
    assign write_offset = cnt;
    assign write_last   = write_en && (cnt == last_q);
    // ready comes back together with the done pulse
    assign ready        = (state != ST_WRITE);
    assign done         = (state == ST_DONE);

endmodule

//--- hdl/kv_write_client.sv
// rejected beats are lost, not retried; error_code is only meaningful once dest_done pulses
module kv_write_client #(
    parameter int  DATA_WIDTH = 256,
    localparam int NUM_DW     = DATA_WIDTH / 32
) (
    input  logic                                    clk,
    input  logic                                    rst_b,
    input  logic                                    zeroize,
    input  logic [kv_defines_pkg::KV_DWORD_OFF_W:0] num_dwords,
    input  kv_defines_pkg::kv_write_ctrl_reg_t      write_ctrl_reg,
    output kv_defines_pkg::kv_write_t               kv_write,
    input  kv_defines_pkg::kv_wr_resp_t             kv_resp,
    output logic                                    dest_keyvault,
    input  logic                                    dest_data_avail,
    input  logic [NUM_DW-1:0][31:0]                 dest_data,
    output kv_defines_pkg::kv_error_code_e          error_code,
    output logic                                    kv_ready,
    output logic                                    dest_done
);
    localparam int OFF_W = kv_defines_pkg::KV_DWORD_OFF_W;

    logic [OFF_W-1:0] read_offset;
    logic [OFF_W-1:0] write_offset;
    logic             beat_en;
    logic             beat_last;
    logic             fsm_start;

    // enable is still high in the done cycle, so block a restart there
    assign fsm_start = dest_data_avail & write_ctrl_reg.write_en & ~dest_done;

    kv_fsm #(
        .DATA_WIDTH (DATA_WIDTH)
    ) kv_dest_fsm_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .zeroize      (zeroize),
        .start        (fsm_start),
        .num_dwords   (num_dwords),
        .read_offset  (read_offset),
        .write_offset (write_offset),
        .write_en     (beat_en),
        .write_last   (beat_last),
        .ready        (kv_ready),
        .done         (dest_done)
    );

    // vault destination is selected while the enable is set
    assign dest_keyvault = write_ctrl_reg.write_en;

    always_comb begin
        kv_write.write_en     = beat_en;
        kv_write.write_entry  = write_ctrl_reg.write_entry;
        kv_write.write_offset = write_offset;
        // most significant dword goes out first
        kv_write.write_data   = dest_data[(NUM_DW - 1) - read_offset];
        // mask only on the final beat, the store uses it as the end marker
        kv_write.write_dest_valid = beat_last ? write_ctrl_reg.write_dest_vld : '0;
    end

    // sticky per transfer: the first beat resets it, any rejected beat fails it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (zeroize) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (beat_en) begin
            if (kv_resp.error) begin
                error_code <= kv_defines_pkg::KV_WRITE_FAIL;
            end else if (write_offset == '0) begin
                error_code <= kv_defines_pkg::KV_SUCCESS;
            end
        end
    end

endmodule

//--- hdl/kv_ctrl_feeder.sv
// host port is a bare strobe with no readback; addresses above NUM_CLIENTS are ignored
module kv_ctrl_feeder #(
    parameter int  NUM_CLIENTS = 3,
    localparam int ADDR_W      = $clog2(NUM_CLIENTS + 1)
) (
    input  logic                               clk,
    input  logic                               rst_b,
    input  logic                               zeroize,
    input  logic                               host_wr,
    input  logic [ADDR_W-1:0]                  host_addr,
    input  kv_defines_pkg::kv_host_word_u      host_wdata,
    input  logic [NUM_CLIENTS-1:0]             dest_done,
    output kv_defines_pkg::kv_write_ctrl_reg_t write_ctrl_reg [NUM_CLIENTS],
    output kv_defines_pkg::kv_lock_cmd_t       lock_cmd,
    output logic                               lock_cmd_vld
);
    // lock commands sit just above the client registers
    localparam logic [ADDR_W-1:0] LOCK_ADDR = ADDR_W'(NUM_CLIENTS);

    logic lock_hit;

    assign lock_hit = host_wr && (host_addr == LOCK_ADDR);

    // client control registers
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                write_ctrl_reg[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                write_ctrl_reg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                if (host_wr && host_addr == ADDR_W'(i)) begin
                    // a fresh host setup wins over completion
                    write_ctrl_reg[i] <= host_wdata.ctrl;
                end else if (dest_done[i]) begin
                    // auto-clear so the client runs once per setup
                    write_ctrl_reg[i].write_en <= 1'b0;
                end
            end
        end
    end

    // one-cycle strobe toward the store
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_cmd_vld <= 1'b0;
        end else if (zeroize) begin
            lock_cmd_vld <= 1'b0;
        end else begin
            lock_cmd_vld <= lock_hit;
        end
    end

    // command payload, only looked at with the strobe
    always_ff @(posedge clk) begin
        if (lock_hit) begin
            lock_cmd <= host_wdata.lock;
        end
    end

endmodule

//--- hdl/kv_store.sv
// a transfer whose last beat carries a zero mask never releases the port; read port is unregistered
module kv_store #(
    parameter int  NUM_CLIENTS = 3,
    localparam int IDX_W       = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst_b,
    input  logic                                      zeroize,
    input  kv_defines_pkg::kv_write_t                 kv_write [NUM_CLIENTS],
    output kv_defines_pkg::kv_wr_resp_t               kv_resp [NUM_CLIENTS],
    input  kv_defines_pkg::kv_lock_cmd_t              lock_cmd,
    input  logic                                      lock_cmd_vld,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]     rd_entry,
    input  logic [kv_defines_pkg::KV_DWORD_OFF_W-1:0] rd_offset,
    output logic [31:0]                               rd_data,
    output logic [kv_defines_pkg::KV_DEST_W-1:0]      rd_dest_vld,
    output logic                                      rd_locked
);
    localparam int NE     = kv_defines_pkg::KV_NUM_ENTRIES;
    localparam int ND     = kv_defines_pkg::KV_NUM_DWORDS;
    localparam int DEST_W = kv_defines_pkg::KV_DEST_W;

    logic [31:0]               data_q [NE][ND];
    logic [DEST_W-1:0]         mask_q [NE];
    logic [NE-1:0]             locked;
    logic                      owner_vld;
    logic [IDX_W-1:0]          owner_idx;
    logic                      claim_vld;
    logic [IDX_W-1:0]          claim_idx;
    logic                      cur_vld;
    logic [IDX_W-1:0]          cur_idx;
    logic                      own_beat;
    kv_defines_pkg::kv_write_t own_wr;
    logic                      acc_vld;

    // first-beat claim, walking down so the lowest index is left standing
    always_comb begin
        claim_vld = 1'b0;
        claim_idx = '0;
        for (int i = NUM_CLIENTS - 1; i >= 0; i--) begin
            if (kv_write[i].write_en && kv_write[i].write_offset == '0) begin
                claim_vld = 1'b1;
                claim_idx = IDX_W'(i);
            end
        end
    end

    // a held port beats any new claim
    assign cur_vld = owner_vld | claim_vld;
    assign cur_idx = owner_vld ? owner_idx : claim_idx;

    // pick the owner beat, reject everyone else
    always_comb begin
        own_beat = 1'b0;
        own_wr   = '0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            kv_resp[i].error = 1'b0;
            if (kv_write[i].write_en) begin
                if (cur_vld && cur_idx == IDX_W'(i)) begin
                    own_beat         = 1'b1;
                    own_wr           = kv_write[i];
                    kv_resp[i].error = locked[kv_write[i].write_entry];
                end else begin
                    kv_resp[i].error = 1'b1;
                end
            end
        end
    end

    assign acc_vld = own_beat && !locked[own_wr.write_entry];

    // ownership follows owner beats even when a lock rejects them
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            owner_vld <= 1'b0;
            owner_idx <= '0;
        end else if (zeroize) begin
            owner_vld <= 1'b0;
        end else if (own_beat) begin
            // nonzero mask marks the last beat
            owner_vld <= (own_wr.write_dest_valid == '0);
            owner_idx <= cur_idx;
        end
    end

    // locks and destination masks
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            locked <= '0;
            for (int e = 0; e < NE; e++) begin
                mask_q[e] <= '0;
            end
        end else if (zeroize) begin
            locked <= '0;
            for (int e = 0; e < NE; e++) begin
                mask_q[e] <= '0;
            end
        end else begin
            if (lock_cmd_vld && lock_cmd.lock_wr) begin
                locked[lock_cmd.entry] <= lock_cmd.set;
            end
            if (acc_vld) begin
                // entry is invalid while it is being rewritten
                if (own_wr.write_offset == '0) begin
                    mask_q[own_wr.write_entry] <= '0;
                end
                if (own_wr.write_dest_valid != '0) begin
                    mask_q[own_wr.write_entry] <= own_wr.write_dest_valid;
                end
            end
        end
    end

    // key storage, wiped by zeroize
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int e = 0; e < NE; e++) begin
                for (int d = 0; d < ND; d++) begin
                    data_q[e][d] <= '0;
                end
            end
        end else if (acc_vld) begin
            data_q[own_wr.write_entry][own_wr.write_offset] <= own_wr.write_data;
        end
    end

    // read-back for checking
    assign rd_data     = data_q[rd_entry][rd_offset];
    assign rd_dest_vld = mask_q[rd_entry];
    assign rd_locked   = locked[rd_entry];

endmodule

//--- hdl/kv_subsys_top.sv
// NUM_CLIENTS identical write clients share one vault port; DATA_WIDTH/32 must fit an entry
module kv_subsys_top #(
    parameter int  DATA_WIDTH  = 256,
    parameter int  NUM_CLIENTS = 3,
    localparam int NUM_DW      = DATA_WIDTH / 32,
    localparam int ADDR_W      = $clog2(NUM_CLIENTS + 1)
) (
    input  logic                                          clk,
    input  logic                                          rst_b,
    input  logic                                          zeroize,
    input  logic [kv_defines_pkg::KV_DWORD_OFF_W:0]       num_dwords,
    input  logic                                          host_wr,
    input  logic [ADDR_W-1:0]                             host_addr,
    input  kv_defines_pkg::kv_host_word_u                 host_wdata,
    input  logic [NUM_CLIENTS-1:0]                        dest_data_avail,
    input  logic [NUM_CLIENTS-1:0][NUM_DW-1:0][31:0]      dest_data,
    output logic [NUM_CLIENTS-1:0]                        dest_keyvault,
    output logic [NUM_CLIENTS-1:0]                        kv_ready,
    output logic [NUM_CLIENTS-1:0]                        dest_done,
    output kv_defines_pkg::kv_error_code_e                error_code [NUM_CLIENTS],
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]         rd_entry,
    input  logic [kv_defines_pkg::KV_DWORD_OFF_W-1:0]     rd_offset,
    output logic [31:0]                                   rd_data,
    output logic [kv_defines_pkg::KV_DEST_W-1:0]          rd_dest_vld,
    output logic                                          rd_locked
);
    kv_defines_pkg::kv_write_ctrl_reg_t write_ctrl_reg [NUM_CLIENTS];
    kv_defines_pkg::kv_write_t          kv_write [NUM_CLIENTS];
    kv_defines_pkg::kv_wr_resp_t        kv_resp [NUM_CLIENTS];
    kv_defines_pkg::kv_lock_cmd_t       lock_cmd;
    logic                               lock_cmd_vld;

    // a client word wider than an entry cannot be stored
    if (NUM_DW > kv_defines_pkg::KV_NUM_DWORDS) begin : g_width_chk
        $error("DATA_WIDTH does not fit one vault entry");
    end

    kv_ctrl_feeder #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) kv_ctrl_feeder_i (
        .clk            (clk),
        .rst_b          (rst_b),
        .zeroize        (zeroize),
        .host_wr        (host_wr),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .dest_done      (dest_done),
        .write_ctrl_reg (write_ctrl_reg),
        .lock_cmd       (lock_cmd),
        .lock_cmd_vld   (lock_cmd_vld)
    );

    // one client per crypto core
    for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_client
        kv_write_client #(
            .DATA_WIDTH (DATA_WIDTH)
        ) kv_write_client_i (
            .clk             (clk),
            .rst_b           (rst_b),
            .zeroize         (zeroize),
            .num_dwords      (num_dwords),
            .write_ctrl_reg  (write_ctrl_reg[g]),
            .kv_write        (kv_write[g]),
            .kv_resp         (kv_resp[g]),
            .dest_keyvault   (dest_keyvault[g]),
            .dest_data_avail (dest_data_avail[g]),
            .dest_data       (dest_data[g]),
            .error_code      (error_code[g]),
            .kv_ready        (kv_ready[g]),
            .dest_done       (dest_done[g])
        );
    end

    kv_store #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) kv_store_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .zeroize      (zeroize),
        .kv_write     (kv_write),
        .kv_resp      (kv_resp),
        .lock_cmd     (lock_cmd),
        .lock_cmd_vld (lock_cmd_vld),
        .rd_entry     (rd_entry),
        .rd_offset    (rd_offset),
        .rd_data      (rd_data),
        .rd_dest_vld  (rd_dest_vld),
        .rd_locked    (rd_locked)
    );

endmodule

//--- verification/kv_tb_clk.sv
// free-running clock from time zero; rst_b is released on a rising edge after RST_CYCLES edges
module kv_tb_clk #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_b
);
    // symmetric clock, first rising edge at PERIOD/2
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset held low for a fixed number of cycles
    initial begin
        rst_b = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_b <= 1'b1;
    end

endmodule

//--- verification/kv_subsys_sva.sv
// sampled on the rising clock outside reset; fail_cnt is read by the testbench at the end
module kv_subsys_sva #(
    parameter int NUM_CLIENTS = 3
) (
    input logic                                      clk,
    input logic                                      rst_b,
    input kv_defines_pkg::kv_write_t                 kv_write [NUM_CLIENTS],
    input kv_defines_pkg::kv_wr_resp_t               kv_resp [NUM_CLIENTS],
    input logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] locked
);
    int                     fail_cnt = 0;
    logic [NUM_CLIENTS-1:0] granted;
    logic [NUM_CLIENTS-1:0] locked_hit;
    logic [NUM_CLIENTS-1:0] idle_err;

    // per-client view of the port in this cycle
    always_comb begin
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            granted[i]    = kv_write[i].write_en && !kv_resp[i].error;
            locked_hit[i] = granted[i] && locked[kv_write[i].write_entry];
            idle_err[i]   = kv_resp[i].error && !kv_write[i].write_en;
        end
    end

    // only the owner may get a clean response
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_b) $countones(granted) <= 1)
        else begin
            $error("more than one client was granted the vault port");
            fail_cnt++;
        end

    // a locked entry must never take a beat
    a_no_locked_write: assert property (@(posedge clk) disable iff (!rst_b) locked_hit == '0)
        else begin
            $error("a beat to a locked entry was accepted");
            fail_cnt++;
        end

    // error flag belongs to a real beat
    a_err_needs_beat: assert property (@(posedge clk) disable iff (!rst_b) idle_err == '0)
        else begin
            $error("error response without a write beat");
            fail_cnt++;
        end

endmodule

bind kv_store kv_subsys_sva #(
    .NUM_CLIENTS (NUM_CLIENTS)
) kv_subsys_sva_i (
    .clk      (clk),
    .rst_b    (rst_b),
    .kv_write (kv_write),
    .kv_resp  (kv_resp),
    .locked   (locked)
);

//--- verification/kv_subsys_tb.sv
// default 256-bit word and three clients; all started clients of a row share entry and length
module kv_subsys_tb;
    localparam int DATA_WIDTH  = 256;
    localparam int NUM_CLIENTS = 3;
    localparam int NUM_DW      = DATA_WIDTH / 32;
    localparam int ADDR_W      = $clog2(NUM_CLIENTS + 1);
    localparam int OFF_W       = kv_defines_pkg::KV_DWORD_OFF_W;
    localparam int ENT_W       = kv_defines_pkg::KV_ENTRY_W;
    localparam int DEST_W      = kv_defines_pkg::KV_DEST_W;
    localparam int NE          = kv_defines_pkg::KV_NUM_ENTRIES;
    localparam int ND          = kv_defines_pkg::KV_NUM_DWORDS;
    localparam int NUM_ROWS    = 9;

    // one test step
    typedef struct packed {
        logic                   zero;
        logic                   do_lock;
        logic [ENT_W-1:0]       lock_entry;
        logic                   lock_set;
        logic [NUM_CLIENTS-1:0] start;
        logic [ENT_W-1:0]       entry;
        logic [DEST_W-1:0]      dest_vld;
        logic [OFF_W:0]         ndw;
        logic [NUM_CLIENTS-1:0] exp_fail;
        logic [DEST_W-1:0]      exp_mask;
    } row_t;

    // zero, lock, lock entry, lock set, start, entry, mask, num_dwords, expected fail, expected mask
    row_t rows [NUM_ROWS] = '{
        '{1'b1, 1'b0, 3'd0, 1'b0, 3'b001, 3'd2, 4'h3, 4'd0, 3'b000, 4'h3},
        '{1'b0, 1'b1, 3'd2, 1'b1, 3'b010, 3'd2, 4'hc, 4'd0, 3'b010, 4'h3},
        '{1'b0, 1'b0, 3'd0, 1'b0, 3'b011, 3'd5, 4'h5, 4'd0, 3'b010, 4'h5},
        '{1'b0, 1'b0, 3'd0, 1'b0, 3'b100, 3'd6, 4'h8, 4'd3, 3'b000, 4'h8},
        '{1'b0, 1'b0, 3'd0, 1'b0, 3'b110, 3'd1, 4'h6, 4'd5, 3'b100, 4'h6},
        '{1'b0, 1'b1, 3'd2, 1'b0, 3'b100, 3'd2, 4'hf, 4'd2, 3'b000, 4'hf},
        '{1'b0, 1'b1, 3'd2, 1'b1, 3'b111, 3'd2, 4'h1, 4'd0, 3'b111, 4'hf},
        '{1'b1, 1'b0, 3'd0, 1'b0, 3'b000, 3'd2, 4'h0, 4'd0, 3'b000, 4'h0},
        '{1'b0, 1'b0, 3'd0, 1'b0, 3'b001, 3'd2, 4'ha, 4'd0, 3'b000, 4'ha}
    };

    logic                                     clk;
    logic                                     rst_b;
    logic                                     zeroize;
    logic [OFF_W:0]                           num_dwords;
    logic                                     host_wr;
    logic [ADDR_W-1:0]                        host_addr;
    kv_defines_pkg::kv_host_word_u            host_wdata;
    logic [NUM_CLIENTS-1:0]                   dest_data_avail;
    logic [NUM_CLIENTS-1:0][NUM_DW-1:0][31:0] dest_data;
    logic [NUM_CLIENTS-1:0]                   dest_keyvault;
    logic [NUM_CLIENTS-1:0]                   kv_ready;
    logic [NUM_CLIENTS-1:0]                   dest_done;
    kv_defines_pkg::kv_error_code_e           error_code [NUM_CLIENTS];
    logic [ENT_W-1:0]                         rd_entry;
    logic [OFF_W-1:0]                         rd_offset;
    logic [31:0]                              rd_data;
    logic [DEST_W-1:0]                        rd_dest_vld;
    logic                                     rd_locked;

    // reference vault contents and lock bits
    logic [NE-1:0][ND-1:0][31:0]              ref_data;
    logic [NE-1:0]                            ref_lock;
    int                                       seed = 76572;

    kv_tb_clk #(
        .PERIOD     (100),
        .RST_CYCLES (4)
    ) kv_tb_clk_i (
        .clk   (clk),
        .rst_b (rst_b)
    );

    kv_subsys_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_CLIENTS (NUM_CLIENTS)
    ) kv_subsys_top_i (
        .clk             (clk),
        .rst_b           (rst_b),
        .zeroize         (zeroize),
        .num_dwords      (num_dwords),
        .host_wr         (host_wr),
        .host_addr       (host_addr),
        .host_wdata      (host_wdata),
        .dest_data_avail (dest_data_avail),
        .dest_data       (dest_data),
        .dest_keyvault   (dest_keyvault),
        .kv_ready        (kv_ready),
        .dest_done       (dest_done),
        .error_code      (error_code),
        .rd_entry        (rd_entry),
        .rd_offset       (rd_offset),
        .rd_data         (rd_data),
        .rd_dest_vld     (rd_dest_vld),
        .rd_locked       (rd_locked)
    );

    task automatic stop_on_mismatch(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_error(input kv_defines_pkg::kv_error_code_e got,
                               input kv_defines_pkg::kv_error_code_e exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: error_code %0h, expected %0h", what, got, exp));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: data %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_mask(input logic [DEST_W-1:0] got, input logic [DEST_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: mask %0h, expected %0h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    // one host strobe, captured at the following edge
    task automatic host_write(input logic [ADDR_W-1:0] addr,
                              input kv_defines_pkg::kv_host_word_u word);
        @(posedge clk);
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= word;
    endtask

    task automatic run_row(input int idx, input row_t r);
        kv_defines_pkg::kv_host_word_u            word;
        logic [NUM_CLIENTS-1:0][NUM_DW-1:0][31:0] stim;
        int                                       n;
        int                                       win;
        // zero or oversize length means the whole word
        if (r.ndw == '0 || r.ndw > NUM_DW) begin
            n = NUM_DW;
        end else begin
            n = r.ndw;
        end
        win = -1;
        if (r.zero) begin
            @(posedge clk);
            zeroize <= 1'b1;
            @(posedge clk);
            zeroize <= 1'b0;
            ref_data = '0;
            ref_lock = '0;
            @(negedge clk);
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                check_error(error_code[i], kv_defines_pkg::KV_SUCCESS,
                            $sformatf("row %0d client %0d after zeroize", idx, i));
            end
        end
        if (r.do_lock) begin
            word              = '0;
            word.lock.entry   = r.lock_entry;
            word.lock.lock_wr = 1'b1;
            word.lock.set     = r.lock_set;
            host_write(ADDR_W'(NUM_CLIENTS), word);
            ref_lock[r.lock_entry] = r.lock_set;
        end
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            for (int k = 0; k < NUM_DW; k++) begin
                stim[i][k] = $random(seed);
            end
            if (r.start[i]) begin
                word                     = '0;
                word.ctrl.write_en       = 1'b1;
                word.ctrl.write_entry    = r.entry;
                word.ctrl.write_dest_vld = r.dest_vld;
                host_write(ADDR_W'(i), word);
            end
        end
        // last control write is captured here, start is sampled one edge later
        @(posedge clk);
        host_wr         <= 1'b0;
        num_dwords      <= r.ndw;
        dest_data       <= stim;
        dest_data_avail <= r.start;
        // lowest started index owns the port; a locked entry keeps its old words
        for (int i = NUM_CLIENTS - 1; i >= 0; i--) begin
            if (r.start[i]) begin
                win = i;
            end
        end
        if (win >= 0 && !ref_lock[r.entry]) begin
            for (int k = 0; k < n; k++) begin
                ref_data[r.entry][k] = stim[win][NUM_DW - 1 - k];
            end
        end
        if (r.start != '0) begin
            // same start cycle and length, so every done pulses together
            do begin
                @(negedge clk);
            end while ((dest_done & r.start) != r.start);
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                if (r.start[i]) begin
                    check_error(error_code[i], r.exp_fail[i] ? kv_defines_pkg::KV_WRITE_FAIL
                                : kv_defines_pkg::KV_SUCCESS,
                                $sformatf("row %0d client %0d", idx, i));
                end
            end
            // enable auto-clears on the done edge, done itself lasts one cycle
            @(negedge clk);
            check_bit(|(dest_keyvault & r.start), 1'b0,
                      $sformatf("row %0d dest_keyvault after done", idx));
            check_bit(|dest_done, 1'b0, $sformatf("row %0d dest_done not a single pulse", idx));
            // data still available, a restart would drop kv_ready
            @(negedge clk);
            check_bit(&kv_ready, 1'b1, $sformatf("row %0d client restarted", idx));
            @(posedge clk);
            dest_data_avail <= '0;
        end
        for (int k = 0; k < ND; k++) begin
            @(posedge clk);
            rd_entry  <= r.entry;
            rd_offset <= OFF_W'(k);
            @(negedge clk);
            check_word(rd_data, ref_data[r.entry][k], $sformatf("row %0d dword %0d", idx, k));
        end
        check_mask(rd_dest_vld, r.exp_mask, $sformatf("row %0d entry %0d", idx, r.entry));
        check_bit(rd_locked, ref_lock[r.entry], $sformatf("row %0d lock bit", idx));
    endtask

    // watchdog, sized from the row count
    initial begin
        repeat (NUM_ROWS * (ND + 20)) @(posedge clk);
        $display("Simulation timed out: rows did not finish in %0d cycles", NUM_ROWS * (ND + 20));
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        zeroize         = 1'b0;
        num_dwords      = '0;
        host_wr         = 1'b0;
        host_addr       = '0;
        host_wdata      = '0;
        dest_data_avail = '0;
        dest_data       = '0;
        rd_entry        = '0;
        rd_offset       = '0;
        ref_data        = '0;
        ref_lock        = '0;
        @(posedge rst_b);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, rows[i]);
        end
        repeat (2) @(posedge clk);
        // bound assertions count their own failures
        if (kv_subsys_top_i.kv_store_i.kv_subsys_sva_i.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Assertion failures were reported in the vault store");
            $display("ERRORS FOUND");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- build.f
hdl/kv_defines_pkg.sv
hdl/kv_fsm.sv
hdl/kv_write_client.sv
hdl/kv_ctrl_feeder.sv
hdl/kv_store.sv
hdl/kv_subsys_top.sv
verification/kv_tb_clk.sv
verification/kv_subsys_sva.sv
verification/kv_subsys_tb.sv

//--- Bender.yml
package:
  name: kv_subsys

sources:
  # design, in compile order
  - files:
      - hdl/kv_defines_pkg.sv
      - hdl/kv_fsm.sv
      - hdl/kv_write_client.sv
      - hdl/kv_ctrl_feeder.sv
      - hdl/kv_store.sv
      - hdl/kv_subsys_top.sv

  # testbench, with the bound assertions
  - target: test
    files:
      - verification/kv_tb_clk.sv
      - verification/kv_subsys_sva.sv
      - verification/kv_subsys_tb.sv
